// ==== source/pix_defines.svh ====
`ifndef PIX_DEFINES_SVH
`define PIX_DEFINES_SVH

// Image and block geometry
`define PIX_IMAGE_SIZE      32
`define PIX_BLOCK_COUNT     4
`define PIX_BLOCK_W         2

// Datapath widths
`define PIX_DATA_W          12
`define PIX_WORD_W          16

// FIFO depth is 2**PIX_FIFO_AW words
`define PIX_FIFO_AW         3

// Memory power-on wait in clk cycles
`define PIX_RAM_INIT_CYCLES 40

`endif

// ==== source/pix_pkg.sv ====
package pix_pkg;

    // Top-level command port
    typedef enum logic [1:0] {
        cmd_none    = 2'b00,
        cmd_capture = 2'b01,
        cmd_readout = 2'b10,
        cmd_stop    = 2'b11
    } pix_cmd_t;

    // Block memory command strobe
    typedef enum logic [1:0] {
        ram_none  = 2'b00,
        ram_write = 2'b01,
        ram_read  = 2'b10,
        ram_stop  = 2'b11
    } ram_cmd_t;

    typedef enum logic [2:0] {
        idle,
        cap_issue,
        cap_wait_ram,
        cap_wait_fifo,
        cap_copy,
        readout_issue,
        stop_issue
    } ctrl_state_t;

    // Pixel-domain capture engine
    typedef enum logic [2:0] {
        px_idle,
        px_clear,
        px_wait_clear,
        px_wait_invalid,
        px_wait_start,
        px_in_frame
    } capture_state_t;

endpackage

// ==== source/ram_port_if.sv ====
`timescale 1ns/1ns
`include "pix_defines.svh"

interface ram_port_if import pix_pkg::*; ();

    ram_cmd_t                cmd;
    logic [`PIX_BLOCK_W-1:0] cmd_block;

    // Write stream
    logic                    write_trigger;
    logic [`PIX_WORD_W-1:0]  write_data;
    logic                    write_ready;
    logic                    write_done;

    // Read stream, show-ahead
    logic                    read_ready;
    logic [`PIX_WORD_W-1:0]  read_data;
    logic                    read_trigger;
    logic                    read_done;

    modport ctrl (
        output cmd, cmd_block, write_trigger, write_data, read_trigger,
        input  write_ready, write_done, read_ready, read_data, read_done
    );

    modport mem (
        input  cmd, cmd_block, write_trigger, write_data, read_trigger,
        output write_ready, write_done, read_ready, read_data, read_done
    );

endinterface

// ==== source/async_fifo.sv ====
`timescale 1ns/1ns
`include "pix_defines.svh"

module async_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pix_dclk,
    input  logic                   clear_toggle,
    output logic                   clear_ack_toggle,
    input  logic                   write_en,
    input  logic [`PIX_WORD_W-1:0] write_data,
    output logic                   full,
    input  logic                   read_trigger,
    output logic                   read_ready,
    output logic [`PIX_WORD_W-1:0] read_data
);

    localparam int AW    = `PIX_FIFO_AW;
    localparam int DEPTH = 1 << AW;

    logic [`PIX_WORD_W-1:0] mem [DEPTH];

    logic [AW:0] wbin, wgray, wbin_next;
    logic [AW:0] rbin, rgray, rbin_next;
    logic [AW:0] rgray_s1, rgray_s2;
    logic [AW:0] wgray_s1, wgray_s2;
    logic        clr_w, clr_s1, clr_s2, clr_r;

    assign wbin_next = wbin + 1'b1;
    assign rbin_next = rbin + 1'b1;

    // Full when the write pointer is one lap ahead of the read pointer
    assign full       = (wgray == {~rgray_s2[AW:AW-1], rgray_s2[AW-2:0]});
    assign read_ready = (rgray != wgray_s2);
    assign read_data  = mem[rbin[AW-1:0]];

    assign clear_ack_toggle = clr_r;

    // ====================
    // Write side
    // ====================
    always_ff @(posedge pix_dclk or negedge rst_n) begin
        if (!rst_n) begin
            wbin     <= '0;
            wgray    <= '0;
            rgray_s1 <= '0;
            rgray_s2 <= '0;
            clr_w    <= 1'b0;
        end else begin
            rgray_s1 <= rgray;
            rgray_s2 <= rgray_s1;
            if (clear_toggle != clr_w) begin
                clr_w <= clear_toggle;
                wbin  <= '0;
                wgray <= '0;
            end else if (write_en && !full) begin
                wbin  <= wbin_next;
                wgray <= wbin_next ^ (wbin_next >> 1);
            end
        end
    end

    always_ff @(posedge pix_dclk) begin
        if (write_en && !full) begin
            mem[wbin[AW-1:0]] <= write_data;
        end
    end

    // ====================
    // Read side
    // ====================
    // Clear request follows the write side, the ack is toggled back from here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rbin     <= '0;
            rgray    <= '0;
            wgray_s1 <= '0;
            wgray_s2 <= '0;
            clr_s1   <= 1'b0;
            clr_s2   <= 1'b0;
            clr_r    <= 1'b0;
        end else begin
            wgray_s1 <= wgray;
            wgray_s2 <= wgray_s1;
            clr_s1   <= clr_w;
            clr_s2   <= clr_s1;
            if (clr_s2 != clr_r) begin
                clr_r <= clr_s2;
                rbin  <= '0;
                rgray <= '0;
            end else if (read_trigger && read_ready) begin
                rbin  <= rbin_next;
                rgray <= rbin_next ^ (rbin_next >> 1);
            end
        end
    end

endmodule

// ==== source/pix_capture.sv ====
`timescale 1ns/1ns
`include "pix_defines.svh"

module pix_capture
    import pix_pkg::*;
(
    input  logic                   pix_dclk,
    input  logic                   rst_n,
    input  logic                   capture_toggle,
    input  logic [`PIX_DATA_W-1:0] pix_d,
    input  logic                   pix_fv,
    input  logic                   pix_lv,
    output logic                   fifo_clear_toggle,
    input  logic                   fifo_clear_ack_toggle,
    input  logic                   fifo_full,
    output logic                   fifo_write_en,
    output logic [`PIX_WORD_W-1:0] fifo_write_data,
    output logic                   pixel_dropped
);

    capture_state_t         state;
    logic [1:0]             rst_sync;
    logic                   prst_n;
    logic [`PIX_DATA_W-1:0] d_q;
    logic                   fv_q, lv_q;
    logic                   cap_s1, cap_s2, cap_seen;
    logic                   ack_s1, ack_s2;
    logic                   frame_active;

    // Local reset, released on pix_dclk
    always_ff @(posedge pix_dclk or negedge rst_n) begin
        if (!rst_n) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end
    assign prst_n = rst_sync[1];

    always_ff @(posedge pix_dclk) begin
        d_q <= pix_d;
    end

    // The first line may start on the same edge as frame valid
    assign frame_active    = (state == px_in_frame) || (state == px_wait_start);
    assign fifo_write_en   = frame_active && fv_q && lv_q;
    assign fifo_write_data = {{(`PIX_WORD_W-`PIX_DATA_W){1'b0}}, d_q};

    always_ff @(posedge pix_dclk or negedge prst_n) begin
        if (!prst_n) begin
            state             <= px_idle;
            fv_q              <= 1'b0;
            lv_q              <= 1'b0;
            cap_s1            <= 1'b0;
            cap_s2            <= 1'b0;
            cap_seen          <= 1'b0;
            ack_s1            <= 1'b0;
            ack_s2            <= 1'b0;
            fifo_clear_toggle <= 1'b0;
            pixel_dropped     <= 1'b0;
        end else begin
            fv_q   <= pix_fv;
            lv_q   <= pix_lv;
            cap_s1 <= capture_toggle;
            cap_s2 <= cap_s1;
            ack_s1 <= fifo_clear_ack_toggle;
            ack_s2 <= ack_s1;

            case (state)
                px_clear: begin
                    fifo_clear_toggle <= ~fifo_clear_toggle;
                    pixel_dropped     <= 1'b0;
                    state             <= px_wait_clear;
                end
                px_wait_clear:   if (ack_s2 == fifo_clear_toggle) state <= px_wait_invalid;
                // Skip a frame already in progress
                px_wait_invalid: if (!fv_q) state <= px_wait_start;
                px_wait_start:   if (fv_q) state <= px_in_frame;
                px_in_frame:     if (!fv_q) state <= px_idle;
                default: ;
            endcase

            if (fifo_write_en && fifo_full) begin
                pixel_dropped <= 1'b1;
            end

            if (cap_s2 != cap_seen) begin
                cap_seen <= cap_s2;
                state    <= px_clear;
            end
        end
    end

endmodule

// ==== source/block_ram_controller.sv ====
`timescale 1ns/1ns
`include "pix_defines.svh"

module block_ram_controller
    import pix_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    ram_port_if.mem port
);

    localparam int IDX_W  = $clog2(`PIX_IMAGE_SIZE);
    localparam int ADDR_W = `PIX_BLOCK_W + IDX_W;
    localparam int INIT_W = $clog2(`PIX_RAM_INIT_CYCLES + 1);

    logic [`PIX_WORD_W-1:0]  mem [`PIX_BLOCK_COUNT * `PIX_IMAGE_SIZE];

    ram_cmd_t                session;
    logic [`PIX_BLOCK_W-1:0] blk;
    logic [IDX_W-1:0]        idx;
    logic [ADDR_W-1:0]       addr;
    logic [INIT_W-1:0]       init_cnt;
    logic                    init_done;
    logic                    phase;
    logic                    wr_accept, rd_accept, last;

    assign init_done = (init_cnt == INIT_W'(`PIX_RAM_INIT_CYCLES));
    assign addr      = {blk, idx};
    assign last      = (idx == IDX_W'(`PIX_IMAGE_SIZE - 1));

    // One write slot every second cycle once the power-on wait is over
    assign port.write_ready = init_done && (session == ram_write) && phase;
    assign port.read_ready  = (session == ram_read);
    assign port.read_data   = mem[addr];

    assign wr_accept = port.write_trigger && port.write_ready;
    assign rd_accept = port.read_trigger && port.read_ready;

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[addr] <= port.write_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            session         <= ram_none;
            blk             <= '0;
            idx             <= '0;
            init_cnt        <= '0;
            phase           <= 1'b0;
            port.write_done <= 1'b0;
            port.read_done  <= 1'b0;
        end else begin
            port.write_done <= 1'b0;
            port.read_done  <= 1'b0;
            if (!init_done) begin
                init_cnt <= init_cnt + 1'b1;
            end
            if (session == ram_write) begin
                phase <= ~phase;
            end

            // Session end after the last word of the block
            if (wr_accept || rd_accept) begin
                idx <= idx + 1'b1;
                if (last) begin
                    session         <= ram_none;
                    port.write_done <= wr_accept;
                    port.read_done  <= rd_accept;
                end
            end

            case (port.cmd)
                ram_write, ram_read: begin
                    session <= port.cmd;
                    blk     <= port.cmd_block;
                    idx     <= '0;
                    phase   <= 1'b0;
                end
                ram_stop: session <= ram_none;
                default: ;
            endcase
        end
    end

endmodule

// ==== source/pix_controller.sv ====
`timescale 1ns/1ns
`include "pix_defines.svh"

module pix_controller
    import pix_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  pix_cmd_t                cmd,
    input  logic [`PIX_BLOCK_W-1:0] cmd_block,
    output logic                    capture_done,
    output logic                    capture_pixel_dropped,
    output logic                    readout_ready,
    input  logic                    readout_trigger,
    output logic [`PIX_WORD_W-1:0]  readout_data,
    output logic                    readout_done,
    input  logic                    pix_dclk,
    input  logic [`PIX_DATA_W-1:0]  pix_d,
    input  logic                    pix_fv,
    input  logic                    pix_lv,
    ram_port_if.ctrl                ram
);

    ctrl_state_t             state;
    logic [`PIX_BLOCK_W-1:0] blk_q;
    logic                    capture_toggle;
    logic                    ack_s1, ack_s2, ack_seen;
    logic                    drop_s1, drop_s2;

    logic                    fifo_clear_toggle;
    logic                    fifo_clear_ack_toggle;
    logic                    fifo_full;
    logic                    fifo_write_en;
    logic [`PIX_WORD_W-1:0]  fifo_write_data;
    logic                    fifo_read_trigger;
    logic                    fifo_read_ready;
    logic [`PIX_WORD_W-1:0]  fifo_read_data;
    logic                    pixel_dropped;
    logic                    copy_word;

    // ====================
    // Pixel side
    // ====================
    async_fifo u_fifo (
        .clk              (clk),
        .rst_n            (rst_n),
        .pix_dclk         (pix_dclk),
        .clear_toggle     (fifo_clear_toggle),
        .clear_ack_toggle (fifo_clear_ack_toggle),
        .write_en         (fifo_write_en),
        .write_data       (fifo_write_data),
        .full             (fifo_full),
        .read_trigger     (fifo_read_trigger),
        .read_ready       (fifo_read_ready),
        .read_data        (fifo_read_data)
    );

    pix_capture u_capture (
        .pix_dclk              (pix_dclk),
        .rst_n                 (rst_n),
        .capture_toggle        (capture_toggle),
        .pix_d                 (pix_d),
        .pix_fv                (pix_fv),
        .pix_lv                (pix_lv),
        .fifo_clear_toggle     (fifo_clear_toggle),
        .fifo_clear_ack_toggle (fifo_clear_ack_toggle),
        .fifo_full             (fifo_full),
        .fifo_write_en         (fifo_write_en),
        .fifo_write_data       (fifo_write_data),
        .pixel_dropped         (pixel_dropped)
    );

    // ====================
    // Memory port
    // ====================
    // Pop when nothing is pending or the pending word goes out this cycle
    assign fifo_read_trigger = !ram.write_trigger || ram.write_ready;
    assign copy_word = (state == cap_copy) && fifo_read_ready && fifo_read_trigger;

    assign ram.cmd_block    = blk_q;
    assign ram.read_trigger = readout_trigger;
    assign readout_ready    = ram.read_ready;
    assign readout_data     = ram.read_data;
    assign readout_done     = ram.read_done;

    assign capture_pixel_dropped = drop_s2;

    always_ff @(posedge clk) begin
        if (copy_word) begin
            ram.write_data <= fifo_read_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= idle;
            blk_q             <= '0;
            ram.cmd           <= ram_none;
            ram.write_trigger <= 1'b0;
            capture_toggle    <= 1'b0;
            capture_done      <= 1'b0;
            ack_s1            <= 1'b0;
            ack_s2            <= 1'b0;
            ack_seen          <= 1'b0;
            drop_s1           <= 1'b0;
            drop_s2           <= 1'b0;
        end else begin
            ram.cmd           <= ram_none;
            ram.write_trigger <= 1'b0;
            capture_done      <= 1'b0;
            ack_s1            <= fifo_clear_ack_toggle;
            ack_s2            <= ack_s1;
            ack_seen          <= ack_s2;
            drop_s1           <= pixel_dropped;
            drop_s2           <= drop_s1;

            case (state)
                cap_issue: begin
                    ram.cmd <= ram_write;
                    state   <= cap_wait_ram;
                end
                // Memory may still be in its power-on wait
                cap_wait_ram: begin
                    if (ram.write_ready) begin
                        capture_toggle <= ~capture_toggle;
                        state          <= cap_wait_fifo;
                    end
                end
                cap_wait_fifo: if (ack_s2 != ack_seen) state <= cap_copy;
                cap_copy: begin
                    ram.write_trigger <= ram.write_trigger && !ram.write_ready;
                    if (copy_word) begin
                        ram.write_trigger <= 1'b1;
                    end
                    if (ram.write_done) begin
                        capture_done <= 1'b1;
                        state        <= idle;
                    end
                end
                readout_issue: begin
                    ram.cmd <= ram_read;
                    state   <= idle;
                end
                stop_issue: begin
                    ram.cmd <= ram_stop;
                    state   <= idle;
                end
                default: ;
            endcase

            // New command wins over whatever is in progress
            case (cmd)
                cmd_capture: state <= cap_issue;
                cmd_readout: state <= readout_issue;
                cmd_stop:    state <= stop_issue;
                default: ;
            endcase
            if (cmd != cmd_none) begin
                blk_q <= cmd_block;
            end
        end
    end

endmodule

// ==== source/pix_top.sv ====
`timescale 1ns/1ns
`include "pix_defines.svh"

module pix_top
    import pix_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  pix_cmd_t                cmd,
    input  logic [`PIX_BLOCK_W-1:0] cmd_block,
    output logic                    capture_done,
    output logic                    capture_pixel_dropped,
    output logic                    readout_ready,
    input  logic                    readout_trigger,
    output logic [`PIX_WORD_W-1:0]  readout_data,
    output logic                    readout_done,
    input  logic                    pix_dclk,
    input  logic [`PIX_DATA_W-1:0]  pix_d,
    input  logic                    pix_fv,
    input  logic                    pix_lv
);

    ram_port_if ram_bus ();

    pix_controller u_ctrl (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .cmd                   (cmd),
        .cmd_block             (cmd_block),
        .capture_done          (capture_done),
        .capture_pixel_dropped (capture_pixel_dropped),
        .readout_ready         (readout_ready),
        .readout_trigger       (readout_trigger),
        .readout_data          (readout_data),
        .readout_done          (readout_done),
        .pix_dclk              (pix_dclk),
        .pix_d                 (pix_d),
        .pix_fv                (pix_fv),
        .pix_lv                (pix_lv),
        .ram                   (ram_bus)
    );

    block_ram_controller u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .port  (ram_bus)
    );

endmodule

// ==== sim/pix_tb.sv ====
`timescale 1ns/1ns
`include "pix_defines.svh"

module pix_tb
    import pix_pkg::*;
();

    localparam int          CLK_HALF  = 4;
    localparam int          SLOW_HALF = 10;
    localparam int          FAST_HALF = 2;
    localparam int          FRAME_GAP = 100;
    localparam int          LINE_GAP  = 4;
    localparam int          LINES     = 4;
    localparam int          LINE_PIX  = 8;
    localparam int          WORDS     = `PIX_IMAGE_SIZE;
    localparam logic [31:0] SEED      = 32'hb5dc_0d7b;
    // Seven frames of about 375 cycles each plus readouts and idle checks come to ~3500 cycles
    localparam int          TIMEOUT_CYCLES = 20000;

    logic                    clk      = 1'b0;
    logic                    pix_dclk = 1'b0;
    int                      pix_half = SLOW_HALF;
    logic                    rst_n;
    pix_cmd_t                cmd;
    logic [`PIX_BLOCK_W-1:0] cmd_block;
    logic                    capture_done;
    logic                    capture_pixel_dropped;
    logic                    readout_ready;
    logic                    readout_trigger;
    logic [`PIX_WORD_W-1:0]  readout_data;
    logic                    readout_done;
    logic [`PIX_DATA_W-1:0]  pix_d;
    logic                    pix_fv;
    logic                    pix_lv;

    logic [31:0]             rng_state;
    logic [`PIX_DATA_W-1:0]  ref_pix [`PIX_BLOCK_COUNT][WORDS];
    int                      rd_blk, rd_idx;
    int                      readout_done_count, capture_done_count;
    int                      cycle_count, check_count, error_count;
    int                      start;

    pix_top dut_i (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .cmd                   (cmd),
        .cmd_block             (cmd_block),
        .capture_done          (capture_done),
        .capture_pixel_dropped (capture_pixel_dropped),
        .readout_ready         (readout_ready),
        .readout_trigger       (readout_trigger),
        .readout_data          (readout_data),
        .readout_done          (readout_done),
        .pix_dclk              (pix_dclk),
        .pix_d                 (pix_d),
        .pix_fv                (pix_fv),
        .pix_lv                (pix_lv)
    );

    always #(CLK_HALF) clk = ~clk;
    always #(pix_half) pix_dclk = ~pix_dclk;

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Stored word is the recorded pixel zero-extended to the word width
    function automatic logic [`PIX_WORD_W-1:0] expected_word(input int blk, input int idx);
        if (idx >= WORDS) begin
            return 'x;
        end else begin
            return {{(`PIX_WORD_W-`PIX_DATA_W){1'b0}}, ref_pix[blk][idx]};
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic issue_cmd(input pix_cmd_t c, input int blk);
        @(negedge clk);
        cmd       = c;
        cmd_block = `PIX_BLOCK_W'(blk);
        @(negedge clk);
        cmd = cmd_none;
    endtask

    // Sensor model sending one frame with its leading gap
    task automatic send_frame(input logic record, input int blk);
        int idx;
        idx = 0;
        repeat (FRAME_GAP) @(negedge pix_dclk);
        pix_fv = 1'b1;
        repeat (2) @(negedge pix_dclk);
        for (int line = 0; line < LINES; line++) begin
            for (int px = 0; px < LINE_PIX; px++) begin
                rng_state = xorshift(rng_state);
                pix_d     = rng_state[`PIX_DATA_W-1:0];
                pix_lv    = 1'b1;
                if (record) begin
                    ref_pix[blk][idx] = pix_d;
                end
                idx++;
                @(negedge pix_dclk);
            end
            pix_lv = 1'b0;
            pix_d  = '0;
            repeat (LINE_GAP) @(negedge pix_dclk);
        end
        pix_fv = 1'b0;
    endtask

    task automatic wait_capture(input int first);
        while (capture_done_count == first) @(negedge clk);
        repeat (10) @(negedge clk);
        check_value("capture_done pulses", capture_done_count - first, 1);
        check_value("capture_pixel_dropped", 32'(capture_pixel_dropped), 0);
    endtask

    task automatic capture_frame(input int blk);
        int first;
        first = capture_done_count;
        issue_cmd(cmd_capture, blk);
        send_frame(1'b1, blk);
        wait_capture(first);
    endtask

    task automatic run_readout(input int blk, input logic random_trigger);
        int first;
        first  = readout_done_count;
        rd_blk = blk;
        rd_idx = 0;
        issue_cmd(cmd_readout, blk);
        while (readout_done_count == first) begin
            @(negedge clk);
            if (random_trigger) begin
                rng_state       = xorshift(rng_state);
                readout_trigger = rng_state[0];
            end else begin
                readout_trigger = 1'b1;
            end
        end
        readout_trigger = 1'b0;
        repeat (8) @(negedge clk);
        check_value("readout_done pulses", readout_done_count - first, 1);
        check_value("readout words", rd_idx, WORDS);
        check_value("readout_ready after done", 32'(readout_ready), 0);
    endtask

    // ====================
    // Compare process
    // ====================
    // Samples just before each rising edge when inputs and outputs have settled
    always begin
        @(negedge clk);
        #(CLK_HALF - 1);
        if (rst_n) begin
            if (readout_ready && readout_trigger) begin
                check_value("readout_data", 32'(readout_data),
                            32'(expected_word(rd_blk, rd_idx)));
                rd_idx++;
            end
            if (readout_done) begin
                check_value("words before readout_done", rd_idx, WORDS);
                readout_done_count++;
            end
            if (capture_done) begin
                capture_done_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clk cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ====================
    // Test sequence
    // ====================
    initial begin
        rst_n              = 1'b0;
        cmd                = cmd_none;
        cmd_block          = '0;
        readout_trigger    = 1'b0;
        pix_d              = '0;
        pix_fv             = 1'b0;
        pix_lv             = 1'b0;
        rng_state          = SEED;
        rd_blk             = 0;
        rd_idx             = 0;
        readout_done_count = 0;
        capture_done_count = 0;
        cycle_count        = 0;
        check_count        = 0;
        error_count        = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Capture straight after reset has to sit out the memory power-on wait
        capture_frame(1);
        run_readout(1, 1'b0);

        // Frame in progress at the command is skipped
        start = capture_done_count;
        fork
            send_frame(1'b0, 0);
            begin
                wait (pix_lv == 1'b1);
                issue_cmd(cmd_capture, 0);
            end
        join
        send_frame(1'b1, 0);
        wait_capture(start);
        run_readout(0, 1'b0);

        capture_frame(2);
        capture_frame(3);
        run_readout(2, 1'b0);
        run_readout(3, 1'b0);
        run_readout(1, 1'b0);

        // Readout with random back-pressure
        run_readout(2, 1'b1);

        // Fast pixel clock overruns the FIFO
        pix_half = FAST_HALF;
        start    = capture_done_count;
        issue_cmd(cmd_capture, 0);
        send_frame(1'b0, 0);
        repeat (200) @(negedge clk);
        check_value("capture_done during overrun", capture_done_count - start, 0);
        check_value("capture_pixel_dropped", 32'(capture_pixel_dropped), 1);
        issue_cmd(cmd_stop, 0);
        repeat (4) @(negedge clk);
        // Flag stays set until the next capture clears the FIFO
        check_value("capture_pixel_dropped after stop", 32'(capture_pixel_dropped), 1);
        pix_half = SLOW_HALF;
        capture_frame(0);
        run_readout(0, 1'b0);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+source
source/pix_pkg.sv
source/ram_port_if.sv
source/async_fifo.sv
source/pix_capture.sv
source/block_ram_controller.sv
source/pix_controller.sv
source/pix_top.sv
sim/pix_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= pix_tb
FILELIST  ?= sim.f

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard source/*.svh)
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
